// File: source/frame_pkg.sv
// Frame format shared by the datapath and the testbench
// PSN is 24 bits and data 256 bits; report records carry only PSN and type
// Struct field order fixes the bit layout of the buffered entries
`default_nettype none

package frame_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int PSN_W  = 24;
    localparam int DATA_W = 256;

    // Frame type codes as seen on the input port
    typedef enum logic [1:0] {
        TYPE_HEAD = 2'd0,
        TYPE_BODY = 2'd1,
        TYPE_TAIL = 2'd2,
        TYPE_ERR  = 2'd3
    } frame_type_e;

    // ==================================================
    // Records
    // ==================================================
    // Sideband fields, also the report port payload (26 bits)
    typedef struct packed {
        logic [PSN_W-1:0] psn;
        frame_type_e      ftype;
    } frame_meta_t;

    // Full frame on input, correct and error ports (282 bits)
    typedef struct packed {
        frame_meta_t       meta;
        logic [DATA_W-1:0] data;
    } frame_t;

    // Main buffer word, verdict plus prepared frame (283 bits)
    typedef struct packed {
        logic   correct;
        frame_t frame;
    } fifo_entry_t;

endpackage

`default_nettype wire

// File: source/proc_pkg.sv
// Processing constants for the frame pipeline
// Delays must lie in 1..(2**DELAY_W - 1), counters are DELAY_W bits wide
`default_nettype none

package proc_pkg;

    // ==================================================
    // Default stage delays, in clock cycles
    // ==================================================
    localparam int DEF_CORRECT_DELAY = 5;
    localparam int DEF_ERROR_DELAY   = 2;
    localparam int DEF_REPORT_DELAY  = 4;

    // Delay counter width
    localparam int DELAY_W = 3;

    // Default buffer depths
    localparam int DEF_MAIN_DEPTH = 8;
    localparam int DEF_RPT_DEPTH  = 4;

    // Shared by the dispatch and report state machines
    typedef enum logic [1:0] {
        IDLE,
        PROCESS,
        OUTPUT
    } stage_state_e;

endpackage

`default_nettype wire

// File: source/sync_fifo.sv
// Synchronous FIFO with show-ahead read, o_dout is the oldest entry
// Write when full and read when empty are dropped silently
// Storage has no reset; o_dout is undefined while empty
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             i_wr_en,
    input  wire logic [WIDTH-1:0] i_din,
    input  wire logic             i_rd_en,
    output logic      [WIDTH-1:0] o_dout,
    output logic                  o_full,
    output logic                  o_empty
);

    // At least one pointer bit even for a single entry
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_ok;
    logic             rd_ok;

    // Effective operations after flag qualification
    assign wr_ok = i_wr_en && !o_full;
    assign rd_ok = i_rd_en && !o_empty;

    // Pointers wrap at DEPTH, so any depth works
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave count unchanged
            if (wr_ok && !rd_ok) begin
                count <= count + 1'b1;
            end else if (rd_ok && !wr_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    // Data array
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_din;
        end
    end

    assign o_dout  = mem[rd_ptr];
    assign o_full  = (count == (PTR_W + 1)'(DEPTH));
    assign o_empty = (count == '0);

endmodule

`default_nettype wire

// File: source/frame_checker.sv
// Input frame judge, purely combinational on the entry it returns
// State (open-frame flag, expected PSN) moves only on i_accept
// Correct frame: head seen, PSN matches, type not error
`timescale 1ns/1ps
`default_nettype none

module frame_checker (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 i_accept,
    input  wire frame_pkg::frame_t    i_frame,
    output frame_pkg::fifo_entry_t    o_entry
);

    import frame_pkg::*;

    logic             in_frame;
    logic [PSN_W-1:0] exp_psn;
    logic             seq_ok;
    logic             psn_ok;
    logic             type_ok;
    logic             correct;

    // ==================================================
    // Verdict
    // ==================================================
    // A head opens the frame itself
    assign seq_ok  = (i_frame.meta.ftype == TYPE_HEAD) || in_frame;
    assign psn_ok  = (i_frame.meta.psn == exp_psn);
    assign type_ok = (i_frame.meta.ftype != TYPE_ERR);
    assign correct = seq_ok && psn_ok && type_ok;

    // Open-frame tracking, independent of the verdict
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_frame <= 1'b0;
        end else if (i_accept) begin
            if (i_frame.meta.ftype == TYPE_HEAD) begin
                in_frame <= 1'b1;
            end else if (i_frame.meta.ftype == TYPE_TAIL) begin
                in_frame <= 1'b0;
            end
        end
    end

    // Incorrect frames leave the expected PSN untouched
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exp_psn <= '0;
        end else if (i_accept && correct) begin
            exp_psn <= exp_psn + 1'b1;
        end
    end

    // ==================================================
    // Entry for the main buffer
    // ==================================================
    always_comb begin
        o_entry.correct    = correct;
        o_entry.frame.meta = i_frame.meta;
        // Data plus zero-extended PSN, or all zero
        if (correct) begin
            o_entry.frame.data = i_frame.data + DATA_W'(i_frame.meta.psn);
        end else begin
            o_entry.frame.data = '0;
        end
    end

endmodule

`default_nettype wire

// File: source/frame_dispatch.sv
// Delays the head of the main buffer, then offers it on port 2 or port 3
// Starts only when the report buffer has room, so the report push never stalls
// Entry must stay stable at the buffer head until o_pop
`timescale 1ns/1ps
`default_nettype none

module frame_dispatch #(
    parameter int unsigned CORRECT_DELAY = proc_pkg::DEF_CORRECT_DELAY,
    parameter int unsigned ERROR_DELAY   = proc_pkg::DEF_ERROR_DELAY
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire frame_pkg::fifo_entry_t i_entry,
    input  wire logic                   i_empty,
    input  wire logic                   i_rpt_full,
    input  wire logic                   i_ready_2,
    input  wire logic                   i_ready_3,
    output logic                        o_pop,
    output logic                        o_valid_2,
    output frame_pkg::frame_t           o_frame_2,
    output logic                        o_valid_3,
    output frame_pkg::frame_t           o_frame_3,
    output logic                        o_rpt_push,
    output frame_pkg::frame_meta_t      o_rpt_meta
);

    import proc_pkg::*;

    stage_state_e       state;
    stage_state_e       state_nxt;
    logic [DELAY_W-1:0] cnt;
    logic [DELAY_W-1:0] target;
    logic               out_ready;
    logic               done;

    // Delay length and ready select follow the verdict
    assign target    = i_entry.correct ? DELAY_W'(CORRECT_DELAY) : DELAY_W'(ERROR_DELAY);
    assign out_ready = i_entry.correct ? i_ready_2 : i_ready_3;
    assign done      = (state == OUTPUT) && out_ready;

    // ==================================================
    // State and delay counter
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            // Counter runs only while in PROCESS
            if (state == PROCESS) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (!i_empty && !i_rpt_full) begin
                    state_nxt = PROCESS;
                end
            end
            PROCESS: begin
                // Cycles 0..target-1 spent here
                if (cnt == target - 1'b1) begin
                    state_nxt = OUTPUT;
                end
            end
            OUTPUT: begin
                if (out_ready) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // ==================================================
    // Output ports
    // ==================================================
    // Exactly one port per frame
    assign o_valid_2 = (state == OUTPUT) && i_entry.correct;
    assign o_valid_3 = (state == OUTPUT) && !i_entry.correct;
    assign o_frame_2 = i_entry.frame;
    // Error data already zeroed at input
    assign o_frame_3 = i_entry.frame;

    // Handshake retires the entry and queues its report
    assign o_pop      = done;
    assign o_rpt_push = done;
    assign o_rpt_meta = i_entry.frame.meta;

endmodule

`default_nettype wire

// File: source/report_stage.sv
// Report queue for port 4, each record delayed DELAY cycles after it arrives
// Records are presented one at a time and held until i_ready_4
// DELAY must fit the DELAY_W counter and be at least 1
`timescale 1ns/1ps
`default_nettype none

module report_stage #(
    parameter int unsigned DELAY = proc_pkg::DEF_REPORT_DELAY,
    parameter int unsigned DEPTH = proc_pkg::DEF_RPT_DEPTH
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   i_push,
    input  wire frame_pkg::frame_meta_t i_meta,
    input  wire logic                   i_ready_4,
    output logic                        o_full,
    output logic                        o_valid_4,
    output frame_pkg::frame_meta_t      o_meta_4
);

    import frame_pkg::*;
    import proc_pkg::*;

    stage_state_e       state;
    stage_state_e       state_nxt;
    logic [DELAY_W-1:0] cnt;
    logic               rpt_empty;
    logic               rpt_pop;

    // ==================================================
    // Record buffer
    // ==================================================
    // Head record drives the port directly
    sync_fifo #(
        .WIDTH ($bits(frame_meta_t)),
        .DEPTH (DEPTH)
    ) u_rpt_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_wr_en (i_push),
        .i_din   (i_meta),
        .i_rd_en (rpt_pop),
        .o_dout  (o_meta_4),
        .o_full  (o_full),
        .o_empty (rpt_empty)
    );

    // ==================================================
    // Delay FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            if (state == PROCESS) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (!rpt_empty) state_nxt = PROCESS;
            PROCESS: if (cnt == DELAY_W'(DELAY - 1)) state_nxt = OUTPUT;
            OUTPUT:  if (i_ready_4) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign o_valid_4 = (state == OUTPUT);
    // Pop on the accepting cycle
    assign rpt_pop   = o_valid_4 && i_ready_4;

endmodule

`default_nettype wire

// File: source/frame_processor.sv
// Frame processor top, strict FIFO order across ports 2, 3 and 4
// Port 1 is ready whenever the main buffer has room
// Delays and depths set here and passed down
`timescale 1ns/1ps
`default_nettype none

module frame_processor #(
    parameter int unsigned CORRECT_DELAY = proc_pkg::DEF_CORRECT_DELAY,
    parameter int unsigned ERROR_DELAY   = proc_pkg::DEF_ERROR_DELAY,
    parameter int unsigned REPORT_DELAY  = proc_pkg::DEF_REPORT_DELAY,
    parameter int unsigned MAIN_DEPTH    = proc_pkg::DEF_MAIN_DEPTH,
    parameter int unsigned RPT_DEPTH     = proc_pkg::DEF_RPT_DEPTH
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    // Input stream
    input  wire logic                   i_valid_1,
    output logic                        o_ready_1,
    input  wire frame_pkg::frame_t      i_frame_1,
    // Correct frames
    output logic                        o_valid_2,
    input  wire logic                   i_ready_2,
    output frame_pkg::frame_t           o_frame_2,
    // Error frames
    output logic                        o_valid_3,
    input  wire logic                   i_ready_3,
    output frame_pkg::frame_t           o_frame_3,
    // Reports
    output logic                        o_valid_4,
    input  wire logic                   i_ready_4,
    output frame_pkg::frame_meta_t      o_meta_4
);

    import frame_pkg::*;

    logic        accept;
    fifo_entry_t in_entry;
    fifo_entry_t head_entry;
    logic        main_full;
    logic        main_empty;
    logic        main_pop;
    logic        rpt_full;
    logic        rpt_push;
    frame_meta_t rpt_meta;

    assign o_ready_1 = !main_full;
    assign accept    = i_valid_1 && !main_full;

    // ==================================================
    // Input judge and main buffer
    // ==================================================
    frame_checker u_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_accept (accept),
        .i_frame  (i_frame_1),
        .o_entry  (in_entry)
    );

    sync_fifo #(
        .WIDTH ($bits(fifo_entry_t)),
        .DEPTH (MAIN_DEPTH)
    ) u_main_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_wr_en (accept),
        .i_din   (in_entry),
        .i_rd_en (main_pop),
        .o_dout  (head_entry),
        .o_full  (main_full),
        .o_empty (main_empty)
    );

    // ==================================================
    // Output stages
    // ==================================================
    frame_dispatch #(
        .CORRECT_DELAY (CORRECT_DELAY),
        .ERROR_DELAY   (ERROR_DELAY)
    ) u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_entry    (head_entry),
        .i_empty    (main_empty),
        .i_rpt_full (rpt_full),
        .i_ready_2  (i_ready_2),
        .i_ready_3  (i_ready_3),
        .o_pop      (main_pop),
        .o_valid_2  (o_valid_2),
        .o_frame_2  (o_frame_2),
        .o_valid_3  (o_valid_3),
        .o_frame_3  (o_frame_3),
        .o_rpt_push (rpt_push),
        .o_rpt_meta (rpt_meta)
    );

    report_stage #(
        .DELAY (REPORT_DELAY),
        .DEPTH (RPT_DEPTH)
    ) u_report (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_push    (rpt_push),
        .i_meta    (rpt_meta),
        .i_ready_4 (i_ready_4),
        .o_full    (rpt_full),
        .o_valid_4 (o_valid_4),
        .o_meta_4  (o_meta_4)
    );

endmodule

`default_nettype wire

// File: verif/frame_processor_asserts.sv
// Handshake rules on the frame processor output ports
// Hold checks are disabled while reset is low
`timescale 1ns/1ps
`default_nettype none

module frame_processor_asserts (
    input wire logic                   clk,
    input wire logic                   rst_n,
    input wire logic                   o_valid_2,
    input wire logic                   i_ready_2,
    input wire frame_pkg::frame_t      o_frame_2,
    input wire logic                   o_valid_3,
    input wire logic                   i_ready_3,
    input wire frame_pkg::frame_t      o_frame_3,
    input wire logic                   o_valid_4,
    input wire logic                   i_ready_4,
    input wire frame_pkg::frame_meta_t o_meta_4
);

    // ==================================================
    // Offer held with stable payload until taken
    // ==================================================
    a_hold_2: assert property (@(posedge clk) disable iff (!rst_n)
        o_valid_2 && !i_ready_2 |=> o_valid_2 && $stable(o_frame_2))
        else $error("correct port dropped or changed a pending frame");

    a_hold_3: assert property (@(posedge clk) disable iff (!rst_n)
        o_valid_3 && !i_ready_3 |=> o_valid_3 && $stable(o_frame_3))
        else $error("error port dropped or changed a pending frame");

    a_hold_4: assert property (@(posedge clk) disable iff (!rst_n)
        o_valid_4 && !i_ready_4 |=> o_valid_4 && $stable(o_meta_4))
        else $error("report port dropped or changed a pending record");

    // One frame goes to exactly one port
    a_one_port: assert property (@(posedge clk) disable iff (!rst_n)
        !(o_valid_2 && o_valid_3))
        else $error("correct and error ports valid together");

    // Second reset edge onward, state is known
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n ##1 !rst_n |-> !o_valid_2 && !o_valid_3 && !o_valid_4)
        else $error("output valid high during reset");

endmodule

bind frame_processor frame_processor_asserts u_asserts (.*);

`default_nettype wire

// File: verif/tb_frame_processor.sv
// Directed testbench for frame_processor, checked against a queue-based reference model
// Inputs change 1 ns after the rising edge and outputs are sampled on the edge
// DUT runs with its default delays and depths; stops at the first error
`timescale 1ns/1ps
`default_nettype none

module tb_frame_processor;

    import frame_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int WAIT_LIMIT = 2000;
    localparam int CMP_W      = 288;

    logic        clk;
    logic        rst_n;
    logic        i_valid_1;
    logic        o_ready_1;
    frame_t      i_frame_1;
    logic        o_valid_2;
    logic        i_ready_2;
    frame_t      o_frame_2;
    logic        o_valid_3;
    logic        i_ready_3;
    frame_t      o_frame_3;
    logic        o_valid_4;
    logic        i_ready_4;
    frame_meta_t o_meta_4;

    // Reference model state and expected outputs
    logic             m_in_frame;
    logic [PSN_W-1:0] m_exp_psn;
    fifo_entry_t      exp_frames[$];
    frame_meta_t      exp_reports[$];
    int               n_out2 = 0;
    int               n_out3 = 0;
    integer           seed;

    frame_processor u_frame_processor (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ==================================================
    // Checking
    // ==================================================
    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [CMP_W-1:0] got,
                               input logic [CMP_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // Head seen, PSN in sequence, type not error
    task automatic model_accept(input frame_t f);
        fifo_entry_t e;
        logic        ok;
        ok = (f.meta.ftype == TYPE_HEAD || m_in_frame) && (f.meta.psn == m_exp_psn)
             && (f.meta.ftype != TYPE_ERR);
        e.correct    = ok;
        e.frame.meta = f.meta;
        e.frame.data = ok ? f.data + {{(DATA_W - PSN_W){1'b0}}, f.meta.psn} : '0;
        if (f.meta.ftype == TYPE_HEAD) begin
            m_in_frame = 1'b1;
        end else if (f.meta.ftype == TYPE_TAIL) begin
            m_in_frame = 1'b0;
        end
        if (ok) begin
            m_exp_psn = m_exp_psn + 1'b1;
        end
        exp_frames.push_back(e);
        exp_reports.push_back(f.meta);
    endtask

    // Ports 2 and 3 share one queue, so cross-port order is checked too
    task automatic check_frame_out(input string name, input logic on_correct, input frame_t got);
        fifo_entry_t e;
        if (exp_frames.size() == 0) begin
            $display("Frame on %s at %0t ns while none was pending", name, $time);
            stop_on_error();
        end else begin
            e = exp_frames.pop_front();
            check_value({name, " port choice"}, CMP_W'(on_correct), CMP_W'(e.correct));
            check_value(name, CMP_W'(got), CMP_W'(e.frame));
        end
    endtask

    task automatic check_report_out(input frame_meta_t got);
        frame_meta_t m;
        if (exp_reports.size() == 0) begin
            $display("Report at %0t ns while none was pending", $time);
            stop_on_error();
        end else begin
            m = exp_reports.pop_front();
            check_value("o_meta_4", CMP_W'(got), CMP_W'(m));
        end
    endtask

    // Completed output handshakes
    always @(posedge clk) begin
        if (rst_n) begin
            if (o_valid_2 && i_ready_2) begin
                check_frame_out("o_frame_2", 1'b1, o_frame_2);
                n_out2 = n_out2 + 1;
            end
            if (o_valid_3 && i_ready_3) begin
                check_frame_out("o_frame_3", 1'b0, o_frame_3);
                n_out3 = n_out3 + 1;
            end
            if (o_valid_4 && i_ready_4) begin
                check_report_out(o_meta_4);
            end
        end
    end

    task automatic check_port_counts(input int b2, input int b3, input int e2, input int e3);
        check_value("port 2 frame count", CMP_W'(n_out2 - b2), CMP_W'(e2));
        check_value("port 3 frame count", CMP_W'(n_out3 - b3), CMP_W'(e3));
    endtask

    // ==================================================
    // Stimulus helpers
    // ==================================================
    function automatic logic [DATA_W-1:0] random_data();
        logic [DATA_W-1:0] d;
        for (int k = 0; k < DATA_W / 32; k++) begin
            d[k*32 +: 32] = $random(seed);
        end
        return d;
    endfunction

    task automatic set_ready(input logic r2, input logic r3, input logic r4);
        i_ready_2 = r2;
        i_ready_3 = r3;
        i_ready_4 = r4;
    endtask

    // Holds valid until the edge that accepts the frame
    task automatic send_frame(input frame_type_e ftype, input logic [PSN_W-1:0] psn,
                              input logic [DATA_W-1:0] data);
        int cycles;
        cycles               = 0;
        i_frame_1.meta.ftype = ftype;
        i_frame_1.meta.psn   = psn;
        i_frame_1.data       = data;
        i_valid_1            = 1'b1;
        @(posedge clk);
        while (!o_ready_1) begin
            cycles = cycles + 1;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout at %0t ns: input port never became ready", $time);
                stop_on_error();
            end
            @(posedge clk);
        end
        model_accept(i_frame_1);
        #1;
        i_valid_1 = 1'b0;
    endtask

    // Queue sizes read on the falling edge, away from the monitor
    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_frames.size() != 0 || exp_reports.size() != 0) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: %0d frames and %0d reports never came out",
                         exp_frames.size(), exp_reports.size());
                stop_on_error();
            end
        end
        @(posedge clk);
        #1;
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset();
        check_value("o_valid_2", CMP_W'(o_valid_2), CMP_W'(0));
        check_value("o_valid_3", CMP_W'(o_valid_3), CMP_W'(0));
        check_value("o_valid_4", CMP_W'(o_valid_4), CMP_W'(0));
        check_value("o_ready_1", CMP_W'(o_ready_1), CMP_W'(1));
    endtask

    // PSN 0, 1, 2 straight after reset
    task automatic test_in_sequence();
        int b2;
        int b3;
        b2 = n_out2;
        b3 = n_out3;
        send_frame(TYPE_HEAD, m_exp_psn, random_data());
        send_frame(TYPE_BODY, m_exp_psn, random_data());
        send_frame(TYPE_TAIL, m_exp_psn, random_data());
        wait_drained();
        check_port_counts(b2, b3, 3, 0);
    endtask

    task automatic test_incorrect();
        int b2;
        int b3;
        b2 = n_out2;
        b3 = n_out3;
        // No head open yet
        send_frame(TYPE_BODY, m_exp_psn, random_data());
        send_frame(TYPE_TAIL, m_exp_psn, random_data());
        send_frame(TYPE_ERR, m_exp_psn, random_data());
        send_frame(TYPE_HEAD, m_exp_psn + 24'd5, random_data());
        // Expected PSN must not have moved
        send_frame(TYPE_HEAD, m_exp_psn, random_data());
        send_frame(TYPE_TAIL, m_exp_psn, random_data());
        wait_drained();
        check_port_counts(b2, b3, 2, 4);
    endtask

    // A ok, B error type, C ok, D body after the tail
    task automatic test_mixed_order();
        int b2;
        int b3;
        b2 = n_out2;
        b3 = n_out3;
        send_frame(TYPE_HEAD, m_exp_psn, random_data());
        send_frame(TYPE_ERR, m_exp_psn, random_data());
        send_frame(TYPE_TAIL, m_exp_psn, random_data());
        send_frame(TYPE_BODY, m_exp_psn, random_data());
        wait_drained();
        check_port_counts(b2, b3, 2, 2);
    endtask

    task automatic test_backpressure();
        int b2;
        int b3;
        int sent;
        b2   = n_out2;
        b3   = n_out3;
        sent = 1;
        set_ready(1'b0, 1'b0, 1'b0);
        send_frame(TYPE_HEAD, m_exp_psn, random_data());
        while (o_ready_1 && sent < 32) begin
            send_frame(TYPE_BODY, m_exp_psn, random_data());
            sent = sent + 1;
        end
        check_value("o_ready_1", CMP_W'(o_ready_1), CMP_W'(0));
        repeat (10) @(posedge clk);
        #1;
        check_value("o_ready_1", CMP_W'(o_ready_1), CMP_W'(0));
        set_ready(1'b1, 1'b1, 1'b1);
        send_frame(TYPE_TAIL, m_exp_psn, random_data());
        wait_drained();
        check_port_counts(b2, b3, sent + 1, 0);
    endtask

    // Random types, mostly in-sequence PSNs, readies high about 3 in 4 cycles
    task automatic test_random_run();
        logic [31:0] r;
        logic        taken;
        int          sent;
        int          cycles;
        sent   = 0;
        cycles = 0;
        while (sent < 200) begin
            r = $random(seed);
            set_ready(r[8] | r[9], r[10] | r[11], r[12] | r[13]);
            if (!i_valid_1 && r[16:15] != 2'd0) begin
                i_frame_1.meta.ftype = frame_type_e'(r[1:0]);
                i_frame_1.meta.psn   = (r[6:4] == 3'd0) ? m_exp_psn + 1'b1 : m_exp_psn;
                i_frame_1.data       = random_data();
                i_valid_1            = 1'b1;
            end
            @(posedge clk);
            taken  = i_valid_1 && o_ready_1;
            cycles = cycles + 1;
            if (cycles > 200 * 40) begin
                $display("Timeout: only %0d of 200 random frames accepted", sent);
                stop_on_error();
            end
            if (taken) begin
                model_accept(i_frame_1);
                sent = sent + 1;
            end
            #1;
            if (taken) begin
                i_valid_1 = 1'b0;
            end
        end
        set_ready(1'b1, 1'b1, 1'b1);
        wait_drained();
    endtask

    initial begin
        seed       = 32'h3459;
        rst_n      = 1'b0;
        i_valid_1  = 1'b0;
        i_frame_1  = '0;
        m_in_frame = 1'b0;
        m_exp_psn  = '0;
        set_ready(1'b1, 1'b1, 1'b1);
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_in_sequence();
        test_incorrect();
        test_mixed_order();
        test_backpressure();
        test_random_run();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
source/frame_pkg.sv
source/proc_pkg.sv
source/sync_fifo.sv
source/frame_checker.sv
source/frame_dispatch.sv
source/report_stage.sv
source/frame_processor.sv
verif/frame_processor_asserts.sv
verif/tb_frame_processor.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_frame_processor
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
